/* hw/line_buf_pkg.sv */
// Image, pixel and window constants and vector types shared by the line buffer RTL and its testbench
package line_buf_pkg;

    localparam int PIXEL_WIDTH = 24;            // One RGB pixel
    localparam int IMG_WIDTH   = 16;            // Pixels per image line
    localparam int NUM_BANKS   = 5;             // Four lines read while the fifth is written
    localparam int WIN_SIZE    = 4;             // Side of the bicubic kernel

    typedef logic [PIXEL_WIDTH-1:0] pixel_t;

    // Column address within one line
    typedef logic [$clog2(IMG_WIDTH)-1:0] col_addr_t;

    typedef logic [$clog2(NUM_BANKS)-1:0] bank_idx_t;

    // Occupied lines, 0 up to NUM_BANKS
    typedef logic [$clog2(NUM_BANKS+1)-1:0] line_cnt_t;

    // Slot i holds line i of the window, slot 0 is the oldest line
    typedef logic [WIN_SIZE*PIXEL_WIDTH-1:0] column_t;

    // Pixel row*WIN_SIZE+col in slot row*WIN_SIZE+col, row 0 oldest, col 0 leftmost
    typedef logic [WIN_SIZE*WIN_SIZE*PIXEL_WIDTH-1:0] window_t;

endpackage

/* hw/line_sram.sv */
// Storage for one image line, one write port and one read port with registered read data
`timescale 1ns/100ps

module line_sram (
    input  logic                  clk,
    input  logic                  we,
    input  line_buf_pkg::col_addr_t waddr,
    input  line_buf_pkg::pixel_t    wdata,
    input  logic                  re,
    input  line_buf_pkg::col_addr_t raddr,
    output line_buf_pkg::pixel_t    rdata
);

    import line_buf_pkg::*;

    pixel_t mem [IMG_WIDTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // One cycle read latency
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

/* hw/pixel_writer.sv */
// Input side of the line buffer that accepts the raster pixel stream and writes it into the line banks
`timescale 1ns/100ps

module pixel_writer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    pix_valid,
    input  line_buf_pkg::pixel_t    pix_data,
    output logic                    pix_ready,
    input  logic                    space_avail,
    output logic                    wr_en,
    output line_buf_pkg::col_addr_t wr_col,
    output line_buf_pkg::pixel_t    wr_data,
    output logic                    line_commit
);

    import line_buf_pkg::*;

    col_addr_t  col;
    logic [1:0] commit_wait;                    // Cycles left until the commit reaches the count
    logic       accept;
    logic       last_col;

    assign last_col  = (col == col_addr_t'(IMG_WIDTH - 1));
    assign pix_ready = space_avail && (commit_wait == 2'd0);
    assign accept    = pix_valid && pix_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col         <= '0;
            commit_wait <= 2'd0;
            wr_en       <= 1'b0;
            line_commit <= 1'b0;
        end else begin
            wr_en       <= accept;
            line_commit <= accept && last_col;  // Travels with the last column write
            if (accept) begin
                col <= last_col ? '0 : col + 1'b1;
            end
            if (accept && last_col) begin
                commit_wait <= 2'd2;
            end else if (commit_wait != 2'd0) begin
                commit_wait <= commit_wait - 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wr_col  <= col;
            wr_data <= pix_data;
        end
    end

    // A write only lands while a bank is still free
    a_write_has_space: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> space_avail);

endmodule

/* hw/line_bank_array.sv */
// Five rotating line banks, one being written while the four oldest lines are read as a column
`timescale 1ns/100ps

module line_bank_array (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    wr_en,
    input  line_buf_pkg::col_addr_t wr_col,
    input  line_buf_pkg::pixel_t    wr_data,
    input  logic                    line_commit,
    output logic                    space_avail,
    output logic                    lines_ready,
    input  logic                    rd_en,
    input  line_buf_pkg::col_addr_t rd_col,
    output line_buf_pkg::column_t   rd_data,
    input  logic                    line_release
);

    import line_buf_pkg::*;

    bank_idx_t wr_ptr;                          // Bank of the line being written
    bank_idx_t rd_ptr;                          // Bank of the oldest line
    bank_idx_t rd_base;                         // Oldest bank at the time of the read
    line_cnt_t line_cnt;
    pixel_t    bank_rdata [NUM_BANKS];

    // Bank index plus a step, wrapping over the five banks
    function automatic bank_idx_t bank_add(bank_idx_t base, int unsigned step);
        int unsigned sum;
        sum = int'(base) + step;
        if (sum >= NUM_BANKS) begin
            sum = sum - NUM_BANKS;
        end
        return bank_idx_t'(sum);
    endfunction

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        bank_idx_t age;                         // Distance from the oldest line
        logic      bank_we;
        logic      bank_re;

        assign age     = bank_add(bank_idx_t'(b), NUM_BANKS - int'(rd_ptr));
        assign bank_we = wr_en && (wr_ptr == bank_idx_t'(b));
        assign bank_re = rd_en && (age < bank_idx_t'(WIN_SIZE));

        line_sram u_line_sram (
            .clk   (clk),
            .we    (bank_we),
            .waddr (wr_col),
            .wdata (wr_data),
            .re    (bank_re),
            .raddr (rd_col),
            .rdata (bank_rdata[b])
        );
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            line_cnt <= '0;
        end else begin
            if (line_commit) begin
                wr_ptr <= bank_add(wr_ptr, 1);
            end
            if (line_release) begin
                rd_ptr <= bank_add(rd_ptr, 1);
            end
            case ({line_commit, line_release})
                2'b10:   line_cnt <= line_cnt + 1'b1;
                2'b01:   line_cnt <= line_cnt - 1'b1;
                default: line_cnt <= line_cnt;  // Commit and release cancel out
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_base <= rd_ptr;
        end
    end

    // Rotate the bank outputs so slot 0 is the oldest line
    always_comb begin
        for (int i = 0; i < WIN_SIZE; i++) begin
            rd_data[i*PIXEL_WIDTH +: PIXEL_WIDTH] = bank_rdata[bank_add(rd_base, i)];
        end
    end

    assign space_avail = (line_cnt < line_cnt_t'(NUM_BANKS));
    assign lines_ready = (line_cnt >= line_cnt_t'(WIN_SIZE));

    // Writer must hold off while every bank is taken
    a_no_commit_full: assert property (@(posedge clk) disable iff (!rst_n)
        line_commit |-> (line_cnt < line_cnt_t'(NUM_BANKS)));

    // Reader only frees a line after a full window row
    a_no_release_short: assert property (@(posedge clk) disable iff (!rst_n)
        line_release |-> (line_cnt >= line_cnt_t'(WIN_SIZE)));

endmodule

/* hw/window_reader.sv */
// Output side of the line buffer, scans the four oldest lines and streams out 4x4 windows
`timescale 1ns/100ps

module window_reader (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    lines_ready,
    output logic                    rd_en,
    output line_buf_pkg::col_addr_t rd_col,
    input  line_buf_pkg::column_t   rd_data,
    output logic                    line_release,
    output logic                    window_valid,
    input  logic                    window_ready,
    output line_buf_pkg::window_t   window
);

    import line_buf_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        READ,
        SHIFT,
        PRESENT,
        RELEASE
    } reader_state_t;

    reader_state_t state;
    reader_state_t state_nxt;
    col_addr_t     col;                         // Column being read
    logic          last_col;
    logic          win_full;                    // Four columns in the window

    assign last_col = (col == col_addr_t'(IMG_WIDTH - 1));
    assign win_full = (col >= col_addr_t'(WIN_SIZE - 1));

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (lines_ready) begin
                    state_nxt = READ;
                end
            end
            READ:    state_nxt = SHIFT;
            SHIFT:   state_nxt = win_full ? PRESENT : READ;
            PRESENT: begin
                if (window_ready) begin
                    state_nxt = last_col ? RELEASE : READ;
                end
            end
            RELEASE: state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            col   <= '0;
        end else begin
            state <= state_nxt;
            if (state == RELEASE) begin
                col <= '0;
            end else if ((state == SHIFT && !win_full) ||
                         (state == PRESENT && window_ready && !last_col)) begin
                col <= col + 1'b1;
            end
        end
    end

    // New column enters at the right, everything moves one place left
    always_ff @(posedge clk) begin
        if (state == SHIFT) begin
            for (int r = 0; r < WIN_SIZE; r++) begin
                for (int c = 0; c < WIN_SIZE - 1; c++) begin
                    window[(r*WIN_SIZE + c)*PIXEL_WIDTH +: PIXEL_WIDTH] <=
                        window[(r*WIN_SIZE + c + 1)*PIXEL_WIDTH +: PIXEL_WIDTH];
                end
                window[(r*WIN_SIZE + WIN_SIZE - 1)*PIXEL_WIDTH +: PIXEL_WIDTH] <=
                    rd_data[r*PIXEL_WIDTH +: PIXEL_WIDTH];
            end
        end
    end

    assign rd_en        = (state == READ);
    assign rd_col       = col;
    assign window_valid = (state == PRESENT);
    assign line_release = (state == RELEASE);

    // A stalled window must not move or drop
    a_window_hold: assert property (@(posedge clk) disable iff (!rst_n)
        window_valid && !window_ready |=> window_valid && $stable(window));

endmodule

/* hw/bicubic_line_buffer.sv */
// Top of the bicubic line buffer, turns a raster pixel stream into a stream of 4x4 windows
`timescale 1ns/100ps

module bicubic_line_buffer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  pix_valid,
    input  line_buf_pkg::pixel_t  pix_data,
    output logic                  pix_ready,
    output logic                  window_valid,
    input  logic                  window_ready,
    output line_buf_pkg::window_t window
);

    import line_buf_pkg::*;

    logic      wr_en;
    col_addr_t wr_col;
    pixel_t    wr_data;
    logic      line_commit;
    logic      space_avail;
    logic      lines_ready;
    logic      rd_en;
    col_addr_t rd_col;
    column_t   rd_data;
    logic      line_release;

    pixel_writer u_pixel_writer (
        .clk         (clk),
        .rst_n       (rst_n),
        .pix_valid   (pix_valid),
        .pix_data    (pix_data),
        .pix_ready   (pix_ready),
        .space_avail (space_avail),
        .wr_en       (wr_en),
        .wr_col      (wr_col),
        .wr_data     (wr_data),
        .line_commit (line_commit)
    );

    line_bank_array u_line_bank_array (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_en        (wr_en),
        .wr_col       (wr_col),
        .wr_data      (wr_data),
        .line_commit  (line_commit),
        .space_avail  (space_avail),
        .lines_ready  (lines_ready),
        .rd_en        (rd_en),
        .rd_col       (rd_col),
        .rd_data      (rd_data),
        .line_release (line_release)
    );

    window_reader u_window_reader (
        .clk          (clk),
        .rst_n        (rst_n),
        .lines_ready  (lines_ready),
        .rd_en        (rd_en),
        .rd_col       (rd_col),
        .rd_data      (rd_data),
        .line_release (line_release),
        .window_valid (window_valid),
        .window_ready (window_ready),
        .window       (window)
    );

endmodule

/* test/tb_bicubic_line_buffer.sv */
// Directed testbench for the bicubic line buffer, streams a random image and checks every window
`timescale 1ns/100ps

module tb_bicubic_line_buffer;

    import line_buf_pkg::*;

    localparam int NUM_LINES       = 7;                         // Enough lines for four window rows
    localparam int WINS_PER_ROW    = IMG_WIDTH - WIN_SIZE + 1;
    localparam int BP_ROWS         = 3;                         // Window rows under back-pressure
    localparam int STALL_CYCLES    = 4 * IMG_WIDTH;
    localparam int TOTAL_PIXELS    = 2 * NUM_LINES * IMG_WIDTH;
    localparam int WATCHDOG_CYCLES = 40 * TOTAL_PIXELS;

    logic    clk;
    logic    rst_n;
    logic    pix_valid;
    pixel_t  pix_data;
    logic    pix_ready;
    logic    window_valid;
    logic    window_ready;
    window_t window;

    integer  seed = 32'he52a4bcb;
    pixel_t  image [NUM_LINES][IMG_WIDTH];

    bicubic_line_buffer dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .pix_valid    (pix_valid),
        .pix_data     (pix_data),
        .pix_ready    (pix_ready),
        .window_valid (window_valid),
        .window_ready (window_ready),
        .window       (window)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_on_failure();
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped on first error");
    endtask

    function automatic logic random_bit();
        int v;
        v = $random(seed);
        return v[0];
    endfunction

    function automatic int random_gap();
        int v;
        v = $random(seed);
        return int'(v[1:0]);                                   // 0 to 3 idle cycles
    endfunction

    task automatic init_image();
        for (int l = 0; l < NUM_LINES; l++) begin
            for (int c = 0; c < IMG_WIDTH; c++) begin
                image[l][c] = pixel_t'($random(seed));
            end
        end
    endtask

    // Slot i*4+j holds pixel (line r+i, column x+j)
    function automatic window_t expected_window(int r, int x);
        window_t w;
        for (int i = 0; i < WIN_SIZE; i++) begin
            for (int j = 0; j < WIN_SIZE; j++) begin
                w[(i*WIN_SIZE + j)*PIXEL_WIDTH +: PIXEL_WIDTH] = image[r+i][x+j];
            end
        end
        return w;
    endfunction

    task automatic apply_reset();
        rst_n        = 1'b0;
        pix_valid    = 1'b0;
        window_ready = 1'b0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
    endtask

    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic send_pixel(int p);
        logic accepted;
        accepted  = 1'b0;
        pix_valid = 1'b1;
        pix_data  = image[p / IMG_WIDTH][p % IMG_WIDTH];
        while (!accepted) begin
            accepted = pix_ready;                              // Ready is stable until the next rise
            @(negedge clk);
        end
        pix_valid = 1'b0;
    endtask

    task automatic stream_pixels(int first, int last, logic gaps);
        int n;
        for (int p = first; p < last; p++) begin
            send_pixel(p);
            if (gaps) begin
                n = random_gap();
                repeat (n) @(negedge clk);
            end
        end
    endtask

    // Keeps the pending pixel valid on return
    task automatic stream_until_stall(output int accepted);
        int idle;
        accepted = 0;
        idle     = 0;
        while (idle < STALL_CYCLES && accepted < NUM_LINES * IMG_WIDTH) begin
            pix_valid = 1'b1;
            pix_data  = image[accepted / IMG_WIDTH][accepted % IMG_WIDTH];
            if (pix_ready) begin
                accepted++;
                idle = 0;
            end else begin
                idle++;
            end
            @(negedge clk);
        end
    endtask

    task automatic collect_windows(int first_row, int num_rows, logic random_ready);
        int      r;
        int      x;
        logic    held;
        window_t held_win;
        window_t exp_win;
        r    = first_row;
        x    = 0;
        held = 1'b0;
        while (r < first_row + num_rows) begin
            window_ready = random_ready ? random_bit() : 1'b1;
            if (held) begin
                assert (window_valid == 1'b1) else begin
                    $display("** Error: window_valid expected 1, actual %h", window_valid);
                    stop_on_failure();
                end
                assert (window == held_win) else begin
                    $display("** Error: window expected %h, actual %h", held_win, window);
                    stop_on_failure();
                end
            end
            if (window_valid && window_ready) begin
                exp_win = expected_window(r, x);
                assert (window == exp_win) else begin
                    $display("** Error: window at row %0d position %0d expected %h, actual %h",
                             r, x, exp_win, window);
                    stop_on_failure();
                end
                held = 1'b0;
                x++;
                if (x == WINS_PER_ROW) begin
                    x = 0;
                    r++;
                end
            end else begin
                held     = window_valid;
                held_win = window;
            end
            @(negedge clk);
        end
        window_ready = 1'b0;
    endtask

    task automatic check_reset();
        assert (window_valid == 1'b0) else begin
            $display("** Error: window_valid expected 0, actual %h", window_valid);
            stop_on_failure();
        end
        assert (pix_ready == 1'b1) else begin
            $display("** Error: pix_ready expected 1, actual %h", pix_ready);
            stop_on_failure();
        end
    endtask

    task automatic check_fill();
        window_ready = 1'b1;
        stream_pixels(0, 3 * IMG_WIDTH, 1'b0);
        repeat (5 * IMG_WIDTH) begin
            assert (window_valid == 1'b0) else begin
                $display("** Error: window_valid expected 0, actual %h", window_valid);
                stop_on_failure();
            end
            @(negedge clk);
        end
        window_ready = 1'b0;
        stream_pixels(3 * IMG_WIDTH, 4 * IMG_WIDTH, 1'b0);
        while (!window_valid) begin
            @(negedge clk);
        end
    endtask

    task automatic check_first_row();
        collect_windows(0, 1, 1'b0);
    endtask

    task automatic check_backpressure();
        fork
            stream_pixels(4 * IMG_WIDTH, NUM_LINES * IMG_WIDTH, 1'b0);
            collect_windows(1, BP_ROWS, 1'b1);
        join
    endtask

    task automatic check_input_stall();
        int accepted;
        apply_reset();
        window_ready = 1'b0;
        stream_until_stall(accepted);
        assert (accepted <= NUM_BANKS * IMG_WIDTH) else begin
            $display("** Error: accepted pixels expected at most %h, actual %h",
                     NUM_BANKS * IMG_WIDTH, accepted);
            stop_on_failure();
        end
        fork
            stream_pixels(accepted, NUM_LINES * IMG_WIDTH, 1'b1);
            collect_windows(0, 4, 1'b1);                       // Rows 0 to 3 over lines 0 to 6
        join
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the DUT stopped making progress before the tests finished");
        $display("=== FAIL ===");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        rst_n        = 1'b0;
        pix_valid    = 1'b0;
        pix_data     = '0;
        window_ready = 1'b0;
        init_image();
        apply_reset();
        check_reset();
        check_fill();
        check_first_row();
        check_backpressure();
        check_input_stall();
        $display("=== PASS ===");
        $finish;
    end

endmodule

/* sources.f */
hw/line_buf_pkg.sv
hw/line_sram.sv
hw/pixel_writer.sv
hw/line_bank_array.sv
hw/window_reader.sv
hw/bicubic_line_buffer.sv
test/tb_bicubic_line_buffer.sv
